// ==== src/host_pkg.sv ====
package host_pkg;

	// ------------------------------------------------------------------
	// Pipe word and command formats on the host link
	// ------------------------------------------------------------------

	typedef logic [31:0] host_word_t; // One pipe transfer

	// Operation codes in the low bits of a command word
	typedef enum logic [1:0] {
		OP_CONV3 = 2'd0, // 3x3 convolution
		OP_POOL3 = 2'd1, // 3x3 max pooling
		OP_RSVD2 = 2'd2,
		OP_RSVD3 = 2'd3
	} op_e;

	typedef struct packed {
		logic [29:0] unused; // Sent as zero
		op_e         op;
	} host_cmd_t;

	// Operand words that follow each command
	// Halves are packed low half first
	localparam int CONV_OPERAND_WORDS = 10; // 9 pixels, 9 weights, bias
	localparam int POOL_OPERAND_WORDS = 5;  // 9 pixels

	// A result word carries the result pixel sign-extended to 32 bits

endpackage

// ==== src/cnn_pkg.sv ====
package cnn_pkg;

	// ------------------------------------------------------------------
	// Fixed-point data types of the neural cores
	// ------------------------------------------------------------------

	// Q8.8 format
	localparam int PIX_FRAC = 8; // Fraction bits

	// Signed pixel, weight or bias value
	typedef logic signed [15:0] pix_t;

	// 3x3 window in row order
	// Index 0 is the top left pixel
	typedef pix_t [0:8] window_t;

	// One convolution job
	typedef struct packed {
		window_t win;  // Input pixels
		window_t wgt;  // Kernel weights
		pix_t    bias; // Added before the final shift
	} conv_job_t;    // 304 bits

	// Pool jobs carry a bare window_t

endpackage

// ==== src/block_fifo.sv ====
`timescale 1ns/1ps

module block_fifo import host_pkg::*; #(
	parameter int FIFO_DEPTH = 32,
	parameter int BLOCK_SIZE = 8,
	parameter int HEADROOM   = 4
) (
	input  logic                            okClk,
	input  logic                            arst_n,
	input  logic                            wr_en,
	input  host_word_t                      wr_data,
	input  logic                            rd_en,
	output host_word_t                      rd_data,
	output logic                            empty,
	output logic                            full,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count,
	output logic                            space_ok,
	output logic                            block_avail
);
	localparam int CNT_W       = $clog2(FIFO_DEPTH + 1);
	localparam int PTR_W       = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int SPACE_LIMIT = FIFO_DEPTH - HEADROOM - BLOCK_SIZE; // Room for one more block

	host_word_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_wr;
	logic             do_rd;

	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(FIFO_DEPTH));
	assign do_wr   = wr_en && !full;
	assign do_rd   = rd_en && !empty;
	assign rd_data = mem[rd_ptr]; // Head word shows without a read

	always_ff @(posedge okClk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Block throttle flags, one cycle behind count
	// ------------------------------------------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			space_ok    <= 1'b0;
			block_avail <= 1'b0;
		end else begin
			space_ok    <= (int'(count) <= SPACE_LIMIT);
			block_avail <= (int'(count) >= BLOCK_SIZE); // Full block waiting
		end
	end

	// The writer and the reader sit in other modules
	a_no_overflow: assert property (@(posedge okClk) disable iff (!arst_n)
		!(wr_en && full));

	a_no_underflow: assert property (@(posedge okClk) disable iff (!arst_n)
		!(rd_en && empty));

endmodule

// ==== src/conv_3x3.sv ====
`timescale 1ns/1ps

module conv_3x3 import cnn_pkg::*; (
	input  logic      okClk,
	input  logic      arst_n,
	input  logic      job_valid,
	input  conv_job_t job,
	output logic      job_ready,
	output logic      res_valid,
	output pix_t      res,
	input  logic      res_ready
);
	localparam int ACC_W = 36; // Nine products and the bias without overflow

	localparam logic signed [ACC_W-1:0] PIX_MAX = 32767;
	localparam logic signed [ACC_W-1:0] PIX_MIN = -32768;

	logic                    adv;
	logic                    v1;
	logic                    v2;
	logic signed [31:0]      prod_q [9];
	pix_t                    bias_q;
	logic signed [ACC_W-1:0] sum_d;
	logic signed [ACC_W-1:0] acc_q;
	logic signed [ACC_W-1:0] shr_d;
	pix_t                    sat_d;

	// Whole pipe holds while the result waits
	assign adv       = !res_valid || res_ready;
	assign job_ready = adv;

	// ------------------------------------------------------------------
	// Stage 1 products
	// ------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (adv) begin
			for (int i = 0; i < 9; i++)
				prod_q[i] <= job.win[i] * job.wgt[i]; // Q16.16
			bias_q <= job.bias;
		end
	end

	// Stage 2 adder tree
	always_comb begin
		sum_d = ACC_W'(bias_q) <<< PIX_FRAC; // Bias aligned to Q16.16
		for (int i = 0; i < 9; i++)
			sum_d = sum_d + ACC_W'(prod_q[i]);
	end

	always_ff @(posedge okClk) begin
		if (adv)
			acc_q <= sum_d;
	end

	// Stage 3 floor shift and saturation
	always_comb begin
		shr_d = acc_q >>> PIX_FRAC;
		if (shr_d > PIX_MAX)
			sat_d = 16'sh7fff;
		else if (shr_d < PIX_MIN)
			sat_d = 16'sh8000;
		else
			sat_d = shr_d[15:0];
	end

	always_ff @(posedge okClk) begin
		if (adv)
			res <= sat_d;
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			v1        <= 1'b0;
			v2        <= 1'b0;
			res_valid <= 1'b0;
		end else if (adv) begin
			v1        <= job_valid;
			v2        <= v1;
			res_valid <= v2;
		end
	end

	a_res_hold: assert property (@(posedge okClk) disable iff (!arst_n)
		(res_valid && !res_ready) |=> (res_valid && $stable(res)));

endmodule

// ==== src/pool_3x3.sv ====
`timescale 1ns/1ps

module pool_3x3 import cnn_pkg::*; (
	input  logic    okClk,
	input  logic    arst_n,
	input  logic    job_valid,
	input  window_t win,
	output logic    job_ready,
	output logic    res_valid,
	output pix_t    res,
	input  logic    res_ready
);
	logic adv;
	logic v1;
	pix_t grp_q [3]; // Row maxima

	function automatic pix_t max3(pix_t a, pix_t b, pix_t c);
		pix_t m;
		m = (a > b) ? a : b;
		return (m > c) ? m : c;
	endfunction

	assign adv       = !res_valid || res_ready; // Same stall rule as conv
	assign job_ready = adv;

	// ------------------------------------------------------------------
	// Two compare stages
	// ------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (adv) begin
			for (int g = 0; g < 3; g++)
				grp_q[g] <= max3(win[3*g], win[3*g+1], win[3*g+2]);
			res <= max3(grp_q[0], grp_q[1], grp_q[2]);
		end
	end

	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			v1        <= 1'b0;
			res_valid <= 1'b0;
		end else if (adv) begin
			v1        <= job_valid;
			res_valid <= v1;
		end
	end

	a_res_hold: assert property (@(posedge okClk) disable iff (!arst_n)
		(res_valid && !res_ready) |=> (res_valid && $stable(res)));

endmodule

// ==== src/op_sequencer.sv ====
`timescale 1ns/1ps

module op_sequencer import host_pkg::*, cnn_pkg::*; (
	input  logic       okClk,
	input  logic       arst_n,
	input  host_word_t in_data,
	input  logic       in_empty,
	output logic       in_rd,
	output logic       conv_valid,
	output conv_job_t  conv_job,
	input  logic       conv_ready,
	output logic       pool_valid,
	output window_t    pool_win,
	input  logic       pool_ready,
	input  logic       conv_res_valid,
	input  pix_t       conv_res,
	input  logic       pool_res_valid,
	input  pix_t       pool_res,
	output logic       res_ready,
	input  logic       out_full,
	output logic       out_wr,
	output host_word_t out_data
);
	localparam int BUF_W     = CONV_OPERAND_WORDS * 32;
	localparam int POOL_BASE = (CONV_OPERAND_WORDS - POOL_OPERAND_WORDS) * 32;
	localparam int CNT_W     = $clog2(CONV_OPERAND_WORDS + 1);

	typedef enum logic [2:0] {
		ST_IDLE,     // Wait for a command word
		ST_CMD,      // Pop and decode it
		ST_GATHER,   // Pop operand words
		ST_DISPATCH, // Offer the job to a core
		ST_COLLECT   // Wait for the result
	} state_e;

	state_e           state;
	op_e              cur_op;
	host_cmd_t        cmd;
	logic [CNT_W-1:0] words_left;
	logic [BUF_W-1:0] opbuf;
	logic             job_taken;
	logic             res_valid_sel;
	pix_t             res_sel;

	assign cmd   = host_cmd_t'(in_data);
	assign in_rd = ((state == ST_CMD) || (state == ST_GATHER)) && !in_empty;

	assign conv_valid = (state == ST_DISPATCH) && (cur_op == OP_CONV3);
	assign pool_valid = (state == ST_DISPATCH) && (cur_op == OP_POOL3);
	assign job_taken  = (conv_valid && conv_ready) || (pool_valid && pool_ready);

	// Only the dispatched core can answer
	assign res_sel       = (cur_op == OP_POOL3) ? pool_res : conv_res;
	assign res_valid_sel = (cur_op == OP_POOL3) ? pool_res_valid : conv_res_valid;
	assign res_ready     = (state == ST_COLLECT) && !out_full;
	assign out_wr        = res_ready && res_valid_sel;
	assign out_data      = {{16{res_sel[15]}}, res_sel};

	// ------------------------------------------------------------------
	// Command FSM
	// ------------------------------------------------------------------
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			cur_op     <= OP_CONV3;
			words_left <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (!in_empty)
						state <= ST_CMD;
				end
				ST_CMD: begin
					if (in_rd) begin
						cur_op <= cmd.op;
						case (cmd.op)
							OP_CONV3: begin
								words_left <= CNT_W'(CONV_OPERAND_WORDS);
								state      <= ST_GATHER;
							end
							OP_POOL3: begin
								words_left <= CNT_W'(POOL_OPERAND_WORDS);
								state      <= ST_GATHER;
							end
							default: state <= ST_IDLE; // Reserved, dropped
						endcase
					end
				end
				ST_GATHER: begin
					if (in_rd) begin
						words_left <= words_left - 1'b1;
						if (words_left == CNT_W'(1))
							state <= ST_DISPATCH;
					end
				end
				ST_DISPATCH: begin
					if (job_taken)
						state <= ST_COLLECT;
				end
				ST_COLLECT: begin
					if (out_wr)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Operand words shift in from the top
	// A pool job ends up in the upper half of the buffer
	always_ff @(posedge okClk) begin
		if ((state == ST_GATHER) && in_rd)
			opbuf <= {in_data, opbuf[BUF_W-1:32]};
	end

	always_comb begin
		for (int i = 0; i < 9; i++) begin
			conv_job.win[i] = opbuf[16*i +: 16];
			conv_job.wgt[i] = opbuf[16*(9+i) +: 16];
			pool_win[i]     = opbuf[POOL_BASE + 16*i +: 16];
		end
		conv_job.bias = opbuf[16*18 +: 16];
	end

	a_one_job: assert property (@(posedge okClk) disable iff (!arst_n)
		!(conv_valid && pool_valid));

	// No core produces a result it was not given
	a_res_source: assert property (@(posedge okClk) disable iff (!arst_n)
		(conv_res_valid || pool_res_valid) |-> (state == ST_COLLECT));

endmodule

// ==== src/squeeze_core_top.sv ====
`timescale 1ns/1ps

module squeeze_core_top import host_pkg::*, cnn_pkg::*; #(
	parameter int FIFO_DEPTH = 32,
	parameter int BLOCK_SIZE = 8,
	parameter int HEADROOM   = 4
) (
	input  logic       okClk,
	input  logic       arst_n,
	input  logic       in_write,
	input  host_word_t in_data,
	output logic       in_full,
	output logic       in_block_ready,
	input  logic       out_read,
	output host_word_t out_data,
	output logic       out_empty,
	output logic       out_block_ready
);
	host_word_t seq_in_data;
	logic       in_empty;
	logic       in_rd;
	logic       conv_valid;
	conv_job_t  conv_job;
	logic       conv_ready;
	logic       pool_valid;
	window_t    pool_win;
	logic       pool_ready;
	logic       conv_res_valid;
	pix_t       conv_res;
	logic       pool_res_valid;
	pix_t       pool_res;
	logic       res_ready;
	logic       out_full;
	logic       out_wr;
	host_word_t seq_out_data;

	// ------------------------------------------------------------------
	// Host pipe FIFOs
	// ------------------------------------------------------------------
	block_fifo #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.BLOCK_SIZE  (BLOCK_SIZE),
		.HEADROOM    (HEADROOM)
	) in_fifo (
		.okClk       (okClk),
		.arst_n      (arst_n),
		.wr_en       (in_write),
		.wr_data     (in_data),
		.rd_en       (in_rd),
		.rd_data     (seq_in_data),
		.empty       (in_empty),
		.full        (in_full),
		.count       (),
		.space_ok    (in_block_ready), // Room for another block
		.block_avail ()
	);

	block_fifo #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.BLOCK_SIZE  (BLOCK_SIZE),
		.HEADROOM    (HEADROOM)
	) out_fifo (
		.okClk       (okClk),
		.arst_n      (arst_n),
		.wr_en       (out_wr),
		.wr_data     (seq_out_data),
		.rd_en       (out_read),
		.rd_data     (out_data),
		.empty       (out_empty),
		.full        (out_full),
		.count       (),
		.space_ok    (),
		.block_avail (out_block_ready) // Full block for the host
	);

	// Control sequencer
	op_sequencer op_sequencer_ (
		.okClk          (okClk),
		.arst_n         (arst_n),
		.in_data        (seq_in_data),
		.in_empty       (in_empty),
		.in_rd          (in_rd),
		.conv_valid     (conv_valid),
		.conv_job       (conv_job),
		.conv_ready     (conv_ready),
		.pool_valid     (pool_valid),
		.pool_win       (pool_win),
		.pool_ready     (pool_ready),
		.conv_res_valid (conv_res_valid),
		.conv_res       (conv_res),
		.pool_res_valid (pool_res_valid),
		.pool_res       (pool_res),
		.res_ready      (res_ready),
		.out_full       (out_full),
		.out_wr         (out_wr),
		.out_data       (seq_out_data)
	);

	// ------------------------------------------------------------------
	// Compute cores
	// ------------------------------------------------------------------
	conv_3x3 conv_3x3_ (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.job_valid (conv_valid),
		.job       (conv_job),
		.job_ready (conv_ready),
		.res_valid (conv_res_valid),
		.res       (conv_res),
		.res_ready (res_ready)
	);

	pool_3x3 pool_3x3_ (
		.okClk     (okClk),
		.arst_n    (arst_n),
		.job_valid (pool_valid),
		.win       (pool_win),
		.job_ready (pool_ready),
		.res_valid (pool_res_valid),
		.res       (pool_res),
		.res_ready (res_ready)
	);

endmodule

// ==== test/tb_squeeze_core.sv ====
`timescale 1ns/1ps

module tb_squeeze_core import host_pkg::*; ();

	localparam int FIFO_DEPTH  = 32;
	localparam int BLOCK_SIZE  = 8;
	localparam int HEADROOM    = 4;
	localparam int SPACE_LIMIT = FIFO_DEPTH - HEADROOM - BLOCK_SIZE;
	localparam int N_CONV      = 40;
	localparam int N_POOL      = 40;
	localparam int N_MIX       = 30; // Five rounds of six commands
	localparam int N_BP        = 48; // Enough pool jobs to back up both FIFOs
	localparam int CONV_WORDS  = 1 + CONV_OPERAND_WORDS;
	localparam int POOL_WORDS  = 1 + POOL_OPERAND_WORDS;
	localparam int TOTAL_WORDS = N_CONV * CONV_WORDS + N_POOL * POOL_WORDS
		+ (N_MIX / 6) * (2 * CONV_WORDS + 2 * POOL_WORDS + 2) + N_BP * POOL_WORDS;
	localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS + 2000;
	localparam logic [31:0] SEED = 32'h93be35ed;

	logic       okClk;
	logic       arst_n;
	logic       in_write;
	host_word_t in_data;
	logic       in_full;
	logic       in_block_ready;
	logic       out_read;
	host_word_t out_data;
	logic       out_empty;
	logic       out_block_ready;

	logic [31:0]        rng;
	logic signed [15:0] halves [20]; // Operand halves of the next command
	host_word_t         exp_q [$];
	host_word_t         chk_word;
	logic               chk_valid;
	logic               rd_busy;
	logic               read_on;
	logic               bp_on;
	logic               saw_full;
	logic               saw_throttle;
	logic               saw_block;
	logic [1:0]         rel_cycles;
	int                 cycles;
	int                 errors;
	int                 results_read;
	int                 tests_run;
	int                 test_err0;
	int                 test_res0;
	string              cur_test;

	squeeze_core_top #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.HEADROOM   (HEADROOM)
	) DUT (
		.okClk           (okClk),
		.arst_n          (arst_n),
		.in_write        (in_write),
		.in_data         (in_data),
		.in_full         (in_full),
		.in_block_ready  (in_block_ready),
		.out_read        (out_read),
		.out_data        (out_data),
		.out_empty       (out_empty),
		.out_block_ready (out_block_ready)
	);

	always #4 okClk = ~okClk;

	// Saturating count of cycles since reset release
	always_ff @(posedge okClk or negedge arst_n) begin
		if (!arst_n)
			rel_cycles <= '0;
		else if (rel_cycles != 2'd3)
			rel_cycles <= rel_cycles + 2'd1;
	end

	always @(posedge okClk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles in test %s", CYCLE_LIMIT, cur_test);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------
	a_reset_state: assert property (@(posedge okClk)
		(cycles > 0 && (!arst_n || rel_cycles < 2'd2)) |->
			(out_empty && !in_full && !out_block_ready))
		else begin
			errors++;
			$display("%s: FIFO status flags wrong during or right after reset", cur_test);
		end

	a_space_in_reset: assert property (@(posedge okClk)
		(cycles > 0 && !arst_n) |-> !in_block_ready)
		else begin
			errors++;
			$display("%s: in_block_ready high while reset is held", cur_test);
		end

	a_space_after_reset: assert property (@(posedge okClk)
		(arst_n && rel_cycles == 2'd1) |-> in_block_ready)
		else begin
			errors++;
			$display("%s: in_block_ready did not rise after reset release", cur_test);
		end

	a_result: assert property (@(posedge okClk) disable iff (!arst_n)
		out_read |-> (chk_valid && out_data == chk_word))
		else begin
			errors++;
			if (!chk_valid)
				$display("%s: result %h arrived with no command waiting for it",
					cur_test, $sampled(out_data));
			else
				$display("FAIL %s expected %h actual %h", cur_test, chk_word,
					$sampled(out_data));
		end

	// Throttle flags lag the occupancy by one cycle
	a_in_throttle_off: assert property (@(posedge okClk) disable iff (!arst_n)
		(rel_cycles != 2'd0 && int'(DUT.in_fifo.count) > SPACE_LIMIT) |=> !in_block_ready)
		else begin
			errors++;
			$display("%s: in_block_ready high with the input FIFO over its limit", cur_test);
		end

	a_in_throttle_on: assert property (@(posedge okClk) disable iff (!arst_n)
		(rel_cycles != 2'd0 && int'(DUT.in_fifo.count) <= SPACE_LIMIT) |=> in_block_ready)
		else begin
			errors++;
			$display("%s: in_block_ready low with room for a block", cur_test);
		end

	a_out_block_on: assert property (@(posedge okClk) disable iff (!arst_n)
		(rel_cycles != 2'd0 && int'(DUT.out_fifo.count) >= BLOCK_SIZE) |=> out_block_ready)
		else begin
			errors++;
			$display("%s: out_block_ready low with a full block waiting", cur_test);
		end

	a_out_block_off: assert property (@(posedge okClk) disable iff (!arst_n)
		(rel_cycles != 2'd0 && int'(DUT.out_fifo.count) < BLOCK_SIZE) |=> !out_block_ready)
		else begin
			errors++;
			$display("%s: out_block_ready high with less than a block waiting", cur_test);
		end

	// ----------------------------------------------------------------------
	// Host side processes
	// ----------------------------------------------------------------------
	always begin
		@(negedge okClk);
		if (read_on && arst_n && !out_empty) begin
			rd_busy = 1'b1;
			if (exp_q.size() > 0) begin
				chk_valid = 1'b1;
				chk_word  = exp_q.pop_front();
			end else begin
				chk_valid = 1'b0; // Unexpected word
				chk_word  = '0;
			end
			@(posedge okClk);
			out_read <= 1'b1;
			@(posedge okClk);
			out_read <= 1'b0;
			results_read++;
			rd_busy = 1'b0;
		end
	end

	// Host resumes reading once the input side backs up
	always @(negedge okClk) begin
		if (bp_on) begin
			if (in_full) begin
				saw_full = 1'b1;
				read_on  = 1'b1;
			end
			if (!in_block_ready)
				saw_throttle = 1'b1;
			if (out_block_ready)
				saw_block = 1'b1;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Q8.8 MAC, floor shift, saturation
	function automatic host_word_t conv_model();
		longint acc;
		longint shr;
		acc = longint'(halves[18]) * 256;
		for (int i = 0; i < 9; i++)
			acc += longint'(halves[i]) * longint'(halves[9 + i]);
		shr = acc >>> 8;
		if (shr > 32767)
			shr = 32767;
		else if (shr < -32768)
			shr = -32768;
		return host_word_t'(shr);
	endfunction

	function automatic host_word_t pool_model();
		logic signed [15:0] m;
		m = halves[0];
		for (int i = 1; i < 9; i++)
			if (halves[i] > m)
				m = halves[i];
		return {{16{m[15]}}, m};
	endfunction

	task automatic load_conv_operands(input int k);
		for (int i = 0; i < 20; i++) begin
			rng = xorshift(rng);
			if (i < 9)
				halves[i] = {{6{rng[9]}}, rng[9:0]}; // Pixels
			else if (i < 19)
				halves[i] = {{4{rng[11]}}, rng[11:0]}; // Weights and bias
			else
				halves[i] = rng[15:0]; // Ignored high half
		end
		if (k % 10 == 0) begin
			for (int i = 0; i < 18; i++)
				halves[i] = 16'sh7fff; // Saturates high
		end else if (k % 10 == 1) begin
			for (int i = 0; i < 9; i++) begin
				halves[i]     = 16'sh7fff;
				halves[9 + i] = 16'sh8000; // Saturates low
			end
		end
	endtask

	task automatic load_pool_operands(input int k);
		for (int i = 0; i < 10; i++) begin
			rng = xorshift(rng);
			if (k % 8 == 1)
				halves[i] = {{13{rng[2]}}, rng[2:0]}; // Narrow range gives ties
			else if (k % 8 == 0 && i < 9)
				halves[i] = {1'b1, rng[14:0]}; // All negative
			else
				halves[i] = rng[15:0];
		end
	endtask

	task automatic send_word(input host_word_t w);
		@(negedge okClk);
		while (in_full)
			@(negedge okClk);
		@(posedge okClk);
		in_write <= 1'b1;
		in_data  <= w;
		@(posedge okClk);
		in_write <= 1'b0;
	endtask

	task automatic issue_cmd(input op_e op, input int nwords);
		host_cmd_t cmd;
		cmd    = '0;
		cmd.op = op;
		send_word(host_word_t'(cmd));
		for (int j = 0; j < nwords; j++)
			send_word({halves[2*j+1], halves[2*j]}); // Low half first
	endtask

	task automatic send_conv(input int k);
		load_conv_operands(k);
		exp_q.push_back(conv_model());
		issue_cmd(OP_CONV3, CONV_OPERAND_WORDS);
	endtask

	task automatic send_pool(input int k);
		load_pool_operands(k);
		exp_q.push_back(pool_model());
		issue_cmd(OP_POOL3, POOL_OPERAND_WORDS);
	endtask

	task automatic drain_results();
		@(negedge okClk);
		while (exp_q.size() != 0 || rd_busy)
			@(negedge okClk);
	endtask

	task automatic open_test(input string name);
		cur_test  = name;
		test_err0 = errors;
		test_res0 = results_read;
	endtask

	task automatic close_test();
		tests_run++;
		$display("Test %-12s done: %0d results checked, %0d errors", cur_test,
			results_read - test_res0, errors - test_err0);
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		okClk        = 1'b0;
		arst_n       = 1'b0;
		in_write     = 1'b0;
		in_data      = '0;
		out_read     = 1'b0;
		rng          = SEED;
		chk_word     = '0;
		chk_valid    = 1'b0;
		rd_busy      = 1'b0;
		read_on      = 1'b1;
		bp_on        = 1'b0;
		saw_full     = 1'b0;
		saw_throttle = 1'b0;
		saw_block    = 1'b0;
		cycles       = 0;
		errors       = 0;
		results_read = 0;
		tests_run    = 0;

		open_test("reset");
		repeat (10) @(posedge okClk);
		arst_n <= 1'b1;
		repeat (4) @(posedge okClk);
		close_test();

		open_test("conv");
		for (int k = 0; k < N_CONV; k++)
			send_conv(k);
		drain_results();
		close_test();

		open_test("pool");
		for (int k = 0; k < N_POOL; k++)
			send_pool(k);
		drain_results();
		close_test();

		// Last command of the stream is valid, so its result marks the end
		open_test("mixed");
		for (int i = 0; i < N_MIX; i++) begin
			case (i % 6)
				0, 3:    send_conv(i);
				1, 5:    send_pool(i);
				2:       issue_cmd(OP_RSVD2, 0);
				default: issue_cmd(OP_RSVD3, 0);
			endcase
		end
		drain_results();
		close_test();

		open_test("backpressure");
		read_on = 1'b0;
		bp_on   = 1'b1;
		for (int k = 0; k < N_BP; k++)
			send_pool(k);
		read_on = 1'b1; // All words sent, host drains the rest
		drain_results();
		bp_on = 1'b0;
		if (!saw_full) begin
			errors++;
			$display("%s: in_full never rose while the host held off reading", cur_test);
		end
		if (!saw_throttle) begin
			errors++;
			$display("%s: in_block_ready never dropped", cur_test);
		end
		if (!saw_block) begin
			errors++;
			$display("%s: out_block_ready never rose", cur_test);
		end
		close_test();

		$display("Tests run %0d, results checked %0d, errors %0d", tests_run,
			results_read, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
src/host_pkg.sv
src/cnn_pkg.sv
src/block_fifo.sv
src/conv_3x3.sv
src/pool_3x3.sv
src/op_sequencer.sv
src/squeeze_core_top.sv
test/tb_squeeze_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the squeeze core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_squeeze_core -f vlog.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_squeeze_core > sim.log 2>&1 \
	|| echo "Build or simulation run ended with an error, see build.log and sim.log"

grep -qx "Simulation finished: PASS" sim.log \
	&& echo "Run passed" \
	|| { echo "Run failed, see sim.log"; exit 1; }
